// File: Bender.yml
package:
  name: arcade_shell

sources:
  - src/arcade_pkg.sv
  - src/host_spi_rx.sv
  - src/player_input_map.sv
  - src/core_ctrl.sv
  - src/video_out.sv
  - src/audio_dac.sv
  - src/arcade_shell_top.sv
  - target: simulation
    files:
      - sim/arcade_shell_checker.sv
      - sim/tb_arcade_shell.sv

// File: sim/arcade_shell_checker.sv
// ========================================
// Bound assertions on the shell top level
// Pixel enable, audio, core reset, syncs
// ========================================

module arcade_shell_checker (
	input logic                    clk_sys,
	input logic                    rst_n,
	input logic                    ce_pix,
	input logic                    core_rst_n,
	input logic                    audio_l,
	input logic                    audio_r,
	input arcade_pkg::core_video_t core_video,
	input arcade_pkg::vga_out_t    vga
);

	int fail_cnt = 0;

	ce_pix_single: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ce_pix |=> !ce_pix)
		else begin
			$error("ce_pix high on two consecutive cycles");
			fail_cnt++;
		end

	// The DAC accumulator only has a known value once reset has been applied
	audio_mono: assert property (@(posedge clk_sys) disable iff (!rst_n)
		audio_r == audio_l)
		else begin
			$error("audio_r differs from audio_l");
			fail_cnt++;
		end

	core_rst_follows: assert property (@(posedge clk_sys) !rst_n |-> !core_rst_n)
		else begin
			$error("core_rst_n high while rst_n is low");
			fail_cnt++;
		end

	// The output register must have left reset one cycle earlier
	hsync_inverted: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$past(rst_n) |-> (vga.hsync == !$past(core_video.hsync)))
		else begin
			$error("vga hsync is not the inverse of the previous core hsync");
			fail_cnt++;
		end

endmodule

bind arcade_shell_top arcade_shell_checker checker_i (
	.clk_sys    (clk_sys),
	.rst_n      (rst_n),
	.ce_pix     (ce_pix),
	.core_rst_n (core_rst_n),
	.audio_l    (audio_l),
	.audio_r    (audio_r),
	.core_video (core_video),
	.vga        (vga)
);

// File: sim/tb_arcade_shell.sv
// ========================================
// Testbench for the arcade board shell
// Clock, reset and LFSR stimulus
// SPI frame driver for the host registers
// Reference model for inputs, VGA and DAC
// ========================================

module tb_arcade_shell;

	logic                     clk_sys;
	logic                     rst_n;
	logic                     spi_sck;
	logic                     spi_ss_n;
	logic                     spi_mosi;
	logic                     button_reset;
	arcade_pkg::core_video_t  core_video;
	logic [7:0]               audio_sample;
	logic                     ce_pix;
	logic                     core_rst_n;
	arcade_pkg::core_inputs_t core_in;
	arcade_pkg::vga_out_t     vga;
	logic                     audio_l;
	logic                     audio_r;

	// Model state mirrors what the host has written and what the video stage holds
	logic [31:0]                lfsr;
	arcade_pkg::option_status_t st_m;
	arcade_pkg::joy_state_t     joy0_m;
	arcade_pkg::joy_state_t     joy1_m;
	logic                       hs_d_m;
	logic                       line_odd_m;
	logic [5:0]                 prev_r_m;
	logic [5:0]                 prev_g_m;
	logic [5:0]                 prev_b_m;

	arcade_shell_top #(
		.dac_bits   (8),
		.reset_hold (16)
	) dut_i (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.spi_sck      (spi_sck),
		.spi_ss_n     (spi_ss_n),
		.spi_mosi     (spi_mosi),
		.button_reset (button_reset),
		.core_video   (core_video),
		.audio_sample (audio_sample),
		.ce_pix       (ce_pix),
		.core_rst_n   (core_rst_n),
		.core_in      (core_in),
		.vga          (vga),
		.audio_l      (audio_l),
		.audio_r      (audio_r)
	);

	always #20 clk_sys = ~clk_sys;

	// ========================================
	// Random numbers and reference model
	// ========================================
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hb4bc_d35c) : (lfsr >> 1);
			val = {val[30:0], lfsr[0]};
		end
		return val;
	endfunction

	function automatic logic [15:0] model_core_in(input arcade_pkg::joy_state_t j0,
		input arcade_pkg::joy_state_t j1, input arcade_pkg::option_status_t st);
		arcade_pkg::joy_state_t m;
		logic [3:0] dir;
		m = j0 | j1;
		// Order is down, left, right, up
		if (st.rotate)
			dir = {m.right, m.down, m.up, m.left};
		else
			dir = {m.down, m.left, m.right, m.up};
		return {8'hff ^ {3'b010, st.rack_test, dir},
			8'hff ^ {1'b0, m.start, m.coin, 4'b0000, m.fire_a}};
	endfunction

	function automatic logic [5:0] model_channel(input logic [5:0] cur,
		input logic [5:0] prev, input logic blend, input logic odd, input logic [1:0] sl);
		logic [6:0] sum;
		logic [5:0] v;
		sum = {1'b0, cur} + {1'b0, prev};
		v = blend ? sum[6:1] : cur;
		if (odd) begin
			case (sl)
				2'd1:    v = v - v / 4;
				2'd2:    v = v / 2;
				2'd3:    v = v / 4;
				default: ;
			endcase
		end
		return v;
	endfunction

	// Predicts vga after the coming rising edge and steps the model state
	task automatic predict_vga(output logic [19:0] expv);
		logic       blank;
		logic [5:0] r;
		logic [5:0] g;
		logic [5:0] b;
		blank = core_video.hblank | core_video.vblank;
		r = blank ? 6'd0 : {2{core_video.r}};
		g = blank ? 6'd0 : {2{core_video.g}};
		b = blank ? 6'd0 : {3{core_video.b}};
		expv = {model_channel(r, prev_r_m, st_m.blend, line_odd_m, st_m.scanlines),
			model_channel(g, prev_g_m, st_m.blend, line_odd_m, st_m.scanlines),
			model_channel(b, prev_b_m, st_m.blend, line_odd_m, st_m.scanlines),
			~core_video.hsync, ~core_video.vsync};
		if (core_video.hsync && !hs_d_m)
			line_odd_m = !line_odd_m;
		hs_d_m = core_video.hsync;
		if (ce_pix) begin
			prev_r_m = r;
			prev_g_m = g;
			prev_b_m = b;
		end
	endtask

	// ========================================
	// Checks, SPI driver and waits
	// ========================================
	task automatic fail_stop(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopping at first failure");
	endtask

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
			fail_stop($sformatf("error %s: expected %h actual %h", name, expected, actual));
	endtask

	always @(negedge clk_sys) begin
		if (dut_i.checker_i.fail_cnt != 0)
			fail_stop("a bound assertion on the shell top level failed");
	end

	// SCK runs at clk_sys / 8 with MSB first while ss_n stays low for the whole frame
	task automatic send_frame(input logic [7:0] cmd, input logic [31:0] data, input int nbits);
		logic [39:0] word;
		word = {cmd, data};
		@(negedge clk_sys);
		spi_ss_n = 1'b0;
		for (int i = 0; i < nbits; i++) begin
			spi_mosi = word[39 - i];
			spi_sck  = 1'b0;
			repeat (4) @(negedge clk_sys);
			spi_sck = 1'b1;
			repeat (4) @(negedge clk_sys);
		end
		spi_sck = 1'b0;
		repeat (4) @(negedge clk_sys);
		spi_ss_n = 1'b1;
		repeat (4) @(negedge clk_sys);
	endtask

	task automatic wait_core_rst(input logic level, input string what);
		int n;
		n = 0;
		while (core_rst_n !== level && n < 200) begin
			@(negedge clk_sys);
			n++;
		end
		if (core_rst_n !== level)
			fail_stop($sformatf("core_rst_n never went to %0d %s", level, what));
	endtask

	task automatic wait_core_in(input string name);
		logic [15:0] expv;
		int          n;
		expv = model_core_in(joy0_m, joy1_m, st_m);
		n = 0;
		while (core_in !== expv && n < 32) begin
			@(negedge clk_sys);
			n++;
		end
		if (core_in !== expv) begin
			$display("core_in did not settle within 32 cycles of the host frame");
			check(name, expv, core_in);
		end
	endtask

	// ========================================
	// Test sequence
	// ========================================
	initial begin
		logic [31:0] rnd;
		logic [15:0] held;
		logic [19:0] exp_vga;
		logic [7:0]  sample;
		int          ones;
		int          diff;
		int          pulses;
		lfsr         = 32'h4811_6472;
		clk_sys      = 1'b0;
		rst_n        = 1'b0;
		spi_sck      = 1'b0;
		spi_ss_n     = 1'b1;
		spi_mosi     = 1'b0;
		button_reset = 1'b0;
		core_video   = '0;
		audio_sample = '0;
		st_m         = '0;
		joy0_m       = '0;
		joy1_m       = '0;
		hs_d_m       = 1'b0;
		line_odd_m   = 1'b0;
		prev_r_m     = '0;
		prev_g_m     = '0;
		prev_b_m     = '0;
		repeat (3) @(negedge clk_sys);
		rst_n = 1'b1;

		// Core reset stretching and the host reset option
		check("core_rst_n held after reset", 0, core_rst_n);
		wait_core_rst(1'b1, "after power-on reset");
		st_m.reset = 1'b1;
		send_frame(arcade_pkg::cmd_status, st_m, 40);
		wait_core_rst(1'b0, "with the reset option set");
		st_m.reset = 1'b0;
		send_frame(arcade_pkg::cmd_status, st_m, 40);
		wait_core_rst(1'b1, "after the reset option cleared");

		// Joystick merge with rotate off and then on
		for (int rot = 0; rot < 2; rot++) begin
			rnd = rand_bits(1);
			st_m.rotate    = rot[0];
			st_m.rack_test = rnd[0];
			send_frame(arcade_pkg::cmd_status, st_m, 40);
			wait_core_in($sformatf("status rotate=%0d", rot));
			for (int k = 0; k < 8; k++) begin
				rnd = rand_bits(13);
				if (rnd[12]) begin
					joy1_m = {20'd0, rnd[11:0]};
					send_frame(arcade_pkg::cmd_joy1, joy1_m, 40);
				end else begin
					joy0_m = {20'd0, rnd[11:0]};
					send_frame(arcade_pkg::cmd_joy0, joy0_m, 40);
				end
				wait_core_in($sformatf("joystick rotate=%0d step %0d", rot, k));
			end
		end

		// Ignored and cut-short frames followed by a full frame to prove recovery
		held = core_in;
		send_frame(8'h7f, rand_bits(32), 40);
		check("unknown command ignored", held, core_in);
		send_frame(arcade_pkg::cmd_joy0, rand_bits(32), 20);
		check("aborted frame discarded", held, core_in);
		rnd = rand_bits(12);
		joy0_m = {20'd0, rnd[11:0]};
		send_frame(arcade_pkg::cmd_joy0, joy0_m, 40);
		wait_core_in("full frame after abort");

		// Video for every scanline and blend setting
		for (int mode = 0; mode < 8; mode++) begin
			st_m.scanlines = mode[1:0];
			st_m.blend     = mode[2];
			send_frame(arcade_pkg::cmd_status, st_m, 40);
			// Video was held at zero during the frame so the stage has settled on it
			hs_d_m   = 1'b0;
			prev_r_m = '0;
			prev_g_m = '0;
			prev_b_m = '0;
			pulses   = 0;
			for (int c = 0; c < 40; c++) begin
				rnd = rand_bits(12);
				core_video = rnd[11:0];
				pulses += ce_pix;
				predict_vga(exp_vga);
				@(negedge clk_sys);
				check($sformatf("vga mode %0d pixel %0d", mode, c), exp_vga, vga);
			end
			// Forty clk_sys cycles hold exactly ten pixel enables
			check($sformatf("ce_pix pulses mode %0d", mode), 10, pulses);
			core_video = '0;
		end

		// DAC density over one full accumulator period
		for (int s = 0; s < 6; s++) begin
			rnd = rand_bits(8);
			sample = rnd[7:0];
			audio_sample = sample;
			ones = 0;
			repeat (256) begin
				@(negedge clk_sys);
				ones += audio_l;
			end
			diff = ones - int'(sample);
			check($sformatf("audio ones for sample %0d", sample), sample,
				(diff >= -1 && diff <= 1) ? sample : ones);
		end

		if (dut_i.checker_i.fail_cnt != 0) begin
			fail_stop("a bound assertion on the shell top level failed");
		end else begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

endmodule

// File: src/arcade_pkg.sv
// ========================================
// Shared definitions for the arcade shell
// Host command codes and payload union
// Core and VGA video structs
// Player input bytes for the game core
// ========================================

package arcade_pkg;

	// ========================================
	// Host commands
	// ========================================
	localparam logic [7:0] cmd_status = 8'h1e;
	localparam logic [7:0] cmd_joy0   = 8'h02;
	localparam logic [7:0] cmd_joy1   = 8'h03;

	// Option word as the host menu sets it
	typedef struct packed {
		logic [24:0] reserved;
		logic        rack_test;
		logic        blend;
		logic [1:0]  scanlines;
		logic        rotate;
		logic        unused_1;
		logic        reset;
	} option_status_t;

	// Joystick word, right is bit 0
	typedef struct packed {
		logic [19:0] reserved;
		logic        start;
		logic        coin;
		logic        fire_f;
		logic        fire_e;
		logic        fire_d;
		logic        fire_c;
		logic        fire_b;
		logic        fire_a;
		logic        up;
		logic        down;
		logic        left;
		logic        right;
	} joy_state_t;

	// The command byte decides which view of the payload is valid
	typedef union packed {
		option_status_t opt;
		joy_state_t     joy;
	} host_payload_u;

	// ========================================
	// Video and inputs
	// ========================================
	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [1:0] b;
		logic       hsync;
		logic       vsync;
		logic       hblank;
		logic       vblank;
	} core_video_t;

	// Syncs are active low on the VGA connector
	typedef struct packed {
		logic [5:0] r;
		logic [5:0] g;
		logic [5:0] b;
		logic       hsync;
		logic       vsync;
	} vga_out_t;

	typedef struct packed {
		logic [7:0] in0;
		logic [7:0] in1;
	} core_inputs_t;

endpackage

// File: src/arcade_shell_top.sv
// ========================================
// Board shell around an arcade game core
// Host SPI, input mapping, core control
// VGA output and audio DAC
// ========================================

module arcade_shell_top #(
	parameter int dac_bits   = 8,
	parameter int reset_hold = 16
) (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  logic                     spi_sck,
	input  logic                     spi_ss_n,
	input  logic                     spi_mosi,
	input  logic                     button_reset,
	input  arcade_pkg::core_video_t  core_video,
	input  logic [dac_bits-1:0]      audio_sample,
	output logic                     ce_pix,
	output logic                     core_rst_n,
	output arcade_pkg::core_inputs_t core_in,
	output arcade_pkg::vga_out_t     vga,
	output logic                     audio_l,
	output logic                     audio_r
);

	arcade_pkg::option_status_t status;
	arcade_pkg::joy_state_t     joy_0;
	arcade_pkg::joy_state_t     joy_1;

	host_spi_rx u_host_spi_rx (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.spi_sck  (spi_sck),
		.spi_ss_n (spi_ss_n),
		.spi_mosi (spi_mosi),
		.status   (status),
		.joy_0    (joy_0),
		.joy_1    (joy_1)
	);

	player_input_map u_player_input_map (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.joy_0   (joy_0),
		.joy_1   (joy_1),
		.status  (status),
		.core_in (core_in)
	);

	core_ctrl #(
		.reset_hold (reset_hold)
	) u_core_ctrl (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.status_reset (status.reset),
		.button_reset (button_reset),
		.ce_pix       (ce_pix),
		.core_rst_n   (core_rst_n)
	);

	video_out u_video_out (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.ce_pix     (ce_pix),
		.core_video (core_video),
		.scanlines  (status.scanlines),
		.blend      (status.blend),
		.vga        (vga)
	);

	audio_dac #(
		.dac_bits (dac_bits)
	) u_audio_dac (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.audio_sample (audio_sample),
		.audio_l      (audio_l)
	);

	// Mono core so both channels share one DAC
	assign audio_r = audio_l;

endmodule

// File: src/audio_dac.sv
// ========================================
// First-order sigma-delta audio DAC
// ========================================

module audio_dac #(
	parameter int dac_bits = 8
) (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  logic [dac_bits-1:0] audio_sample,
	output logic                audio_l
);

	// Top bit holds the carry of the last addition
	logic [dac_bits:0] acc;

	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			acc <= '0;
		else
			acc <= {1'b0, acc[dac_bits-1:0]} + {1'b0, audio_sample};
	end

	// Density of carries follows the sample value
	assign audio_l = acc[dac_bits];

endmodule

// File: src/core_ctrl.sv
// ========================================
// Core control
// Pixel clock enable at clk_sys / 4
// Core reset stretcher
// ========================================

module core_ctrl #(
	parameter int reset_hold = 16
) (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic status_reset,
	input  logic button_reset,
	output logic ce_pix,
	output logic core_rst_n
);

	localparam int cnt_w = $clog2(reset_hold + 1);

	logic [1:0]       div;
	logic [cnt_w-1:0] hold_cnt;
	logic             cause;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			div    <= 2'd0;
			ce_pix <= 1'b0;
		end else begin
			div    <= div + 2'd1;
			ce_pix <= (div == 2'd3);
		end
	end

	assign cause = !rst_n || status_reset || button_reset;

	// Counter sits at reset_hold while any cause is present
	always_ff @(posedge clk_sys) begin
		if (cause)
			hold_cnt <= cnt_w'(reset_hold);
		else if (hold_cnt != '0)
			hold_cnt <= hold_cnt - 1'b1;
	end

	// An active cause pulls the core into reset at once
	assign core_rst_n = !cause && (hold_cnt == '0);

endmodule

// File: src/host_spi_rx.sv
// ========================================
// SPI slave for host configuration
// Collects command byte plus 32-bit payload
// Updates status and joystick registers
// ========================================

module host_spi_rx (
	input  logic                       clk_sys,
	input  logic                       rst_n,
	input  logic                       spi_sck,
	input  logic                       spi_ss_n,
	input  logic                       spi_mosi,
	output arcade_pkg::option_status_t status,
	output arcade_pkg::joy_state_t     joy_0,
	output arcade_pkg::joy_state_t     joy_1
);

	logic [1:0]                sck_sync;
	logic [1:0]                ss_sync;
	logic [1:0]                mosi_sync;
	logic                      sck_d;
	logic                      sck_rise;
	logic                      frame_done;
	logic [38:0]               shift;
	logic [5:0]                bit_cnt;
	logic [39:0]               frame;
	logic [7:0]                cmd;
	arcade_pkg::host_payload_u payload;

	// ========================================
	// Pin synchronisers
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			sck_sync  <= 2'b00;
			ss_sync   <= 2'b11;
			mosi_sync <= 2'b00;
			sck_d     <= 1'b0;
		end else begin
			sck_sync  <= {sck_sync[0], spi_sck};
			ss_sync   <= {ss_sync[0], spi_ss_n};
			mosi_sync <= {mosi_sync[0], spi_mosi};
			sck_d     <= sck_sync[1];
		end
	end

	assign sck_rise   = sck_sync[1] && !sck_d && !ss_sync[1];
	assign frame_done = sck_rise && (bit_cnt == 6'd39);

	// Full frame including the bit being taken right now
	assign frame   = {shift, mosi_sync[1]};
	assign cmd     = frame[39:32];
	assign payload = frame[31:0];

	always_ff @(posedge clk_sys) begin
		if (sck_rise)
			shift <= frame[38:0];
	end

	// Counter restarts whenever select goes inactive, so a short frame is lost
	always_ff @(posedge clk_sys) begin
		if (!rst_n || ss_sync[1]) begin
			bit_cnt <= '0;
		end else if (sck_rise) begin
			if (bit_cnt == 6'd39)
				bit_cnt <= '0;
			else
				bit_cnt <= bit_cnt + 6'd1;
		end
	end

	// ========================================
	// Register update on the last bit
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			status <= '0;
			joy_0  <= '0;
			joy_1  <= '0;
		end else if (frame_done) begin
			case (cmd)
				arcade_pkg::cmd_status: status <= payload.opt;
				arcade_pkg::cmd_joy0:   joy_0  <= payload.joy;
				arcade_pkg::cmd_joy1:   joy_1  <= payload.joy;
				default: ;
			endcase
		end
	end

endmodule

// File: src/player_input_map.sv
// ========================================
// Player input mapping
// Merges both joysticks, rotates controls
// Builds the core's active-low input bytes
// ========================================

module player_input_map (
	input  logic                       clk_sys,
	input  logic                       rst_n,
	input  arcade_pkg::joy_state_t     joy_0,
	input  arcade_pkg::joy_state_t     joy_1,
	input  arcade_pkg::option_status_t status,
	output arcade_pkg::core_inputs_t   core_in
);

	arcade_pkg::joy_state_t merged;
	logic                   dir_up;
	logic                   dir_down;
	logic                   dir_left;
	logic                   dir_right;

	// One-player cabinet so either stick drives player one
	assign merged = joy_0 | joy_1;

	// Quarter turn for a cabinet with the monitor on its side
	always_comb begin
		if (status.rotate) begin
			dir_up    = merged.left;
			dir_right = merged.up;
			dir_down  = merged.right;
			dir_left  = merged.down;
		end else begin
			dir_up    = merged.up;
			dir_right = merged.right;
			dir_down  = merged.down;
			dir_left  = merged.left;
		end
	end

	// Reset values are the bytes an idle stick would give
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			core_in.in0 <= 8'hbf;
			core_in.in1 <= 8'hff;
		end else begin
			core_in.in0 <= ~{1'b0, 1'b1, 1'b0, status.rack_test,
				dir_down, dir_left, dir_right, dir_up};
			core_in.in1 <= ~{1'b0, merged.start, merged.coin, 4'b0000,
				merged.fire_a};
		end
	end

endmodule

// File: src/video_out.sv
// ========================================
// VGA output stage
// Blanking and 3/3/2 to 6/6/6 expansion
// Blend, scanline dimming, sync inversion
// ========================================

module video_out (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  logic                    ce_pix,
	input  arcade_pkg::core_video_t core_video,
	input  logic [1:0]              scanlines,
	input  logic                    blend,
	output arcade_pkg::vga_out_t    vga
);

	logic       blank;
	logic       hs_d;
	logic       line_odd;
	logic [5:0] r_exp, g_exp, b_exp;
	logic [5:0] r_mix, g_mix, b_mix;
	logic [5:0] prev_r, prev_g, prev_b;

	function automatic logic [5:0] avg(input logic [5:0] a, input logic [5:0] b);
		logic [6:0] sum;
		sum = {1'b0, a} + {1'b0, b};
		return sum[6:1];
	endfunction

	// 25% keeps three quarters, 50% keeps half, 75% keeps a quarter
	function automatic logic [5:0] dim(input logic [5:0] v, input logic [1:0] sl);
		case (sl)
			2'd1:    return v - (v >> 2);
			2'd2:    return v >> 1;
			2'd3:    return v >> 2;
			default: return v;
		endcase
	endfunction

	assign blank = core_video.hblank || core_video.vblank;
	assign r_exp = blank ? 6'd0 : {core_video.r, core_video.r};
	assign g_exp = blank ? 6'd0 : {core_video.g, core_video.g};
	assign b_exp = blank ? 6'd0 : {core_video.b, core_video.b, core_video.b};

	// Blend happens before dimming
	assign r_mix = blend ? avg(r_exp, prev_r) : r_exp;
	assign g_mix = blend ? avg(g_exp, prev_g) : g_exp;
	assign b_mix = blend ? avg(b_exp, prev_b) : b_exp;

	always_ff @(posedge clk_sys) begin
		if (ce_pix) begin
			prev_r <= r_exp;
			prev_g <= g_exp;
			prev_b <= b_exp;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			hs_d      <= 1'b0;
			line_odd  <= 1'b0;
			vga.r     <= 6'd0;
			vga.g     <= 6'd0;
			vga.b     <= 6'd0;
			vga.hsync <= 1'b1;
			vga.vsync <= 1'b1;
		end else begin
			hs_d <= core_video.hsync;
			if (core_video.hsync && !hs_d)
				line_odd <= !line_odd;
			vga.r     <= line_odd ? dim(r_mix, scanlines) : r_mix;
			vga.g     <= line_odd ? dim(g_mix, scanlines) : g_mix;
			vga.b     <= line_odd ? dim(b_mix, scanlines) : b_mix;
			vga.hsync <= !core_video.hsync;
			vga.vsync <= !core_video.vsync;
		end
	end

endmodule

// File: vlog.f
src/arcade_pkg.sv
src/host_spi_rx.sv
src/player_input_map.sv
src/core_ctrl.sv
src/video_out.sv
src/audio_dac.sv
src/arcade_shell_top.sv
sim/arcade_shell_checker.sv
sim/tb_arcade_shell.sv
